//--- design/axi_lite_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_arbiter import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  axi_req_t m0_req,
    output axi_rsp_t m0_rsp,
    input  axi_req_t m1_req,
    output axi_rsp_t m1_rsp,
    output axi_req_t bus_req,
    input  axi_rsp_t bus_rsp
);

    arb_state_e state;
    arb_state_e state_nxt;
    logic       last_m1;
    logic       m0_want;
    logic       m1_want;
    logic       done;

    assign m0_want = m0_req.ar.arvalid || m0_req.aw.awvalid;
    assign m1_want = m1_req.ar.arvalid || m1_req.aw.awvalid;

    // Transaction ends on the response handshake
    assign done = (bus_rsp.r.rvalid && bus_req.rready) ||
                  (bus_rsp.b.bvalid && bus_req.bready);

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                if (m0_want && m1_want) begin
                    state_nxt = last_m1 ? ARB_M0 : ARB_M1;
                end else if (m0_want) begin
                    state_nxt = ARB_M0;
                end else if (m1_want) begin
                    state_nxt = ARB_M1;
                end
            end
            ARB_M0, ARB_M1: begin
                if (done) begin
                    state_nxt = ARB_IDLE;
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ARB_IDLE;
            last_m1 <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ARB_IDLE && state_nxt != ARB_IDLE) begin
                last_m1 <= (state_nxt == ARB_M1);
            end
        end
    end

    // Losing master sees everything low
    always_comb begin
        bus_req = '0;
        m0_rsp  = '0;
        m1_rsp  = '0;
        case (state)
            ARB_M0: begin
                bus_req = m0_req;
                m0_rsp  = bus_rsp;
            end
            ARB_M1: begin
                bus_req = m1_req;
                m1_rsp  = bus_rsp;
            end
            default: ;
        endcase
    end

    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        (state != ARB_IDLE) &&
        ((bus_rsp.r.rvalid && !bus_req.rready) || (bus_rsp.b.bvalid && !bus_req.bready))
        |=> $stable(state));

endmodule

`default_nettype wire

//--- design/axi_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_xbar import soc_bus_pkg::*; #(
    parameter int SRAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  axi_req_t up_req,
    output axi_rsp_t up_rsp,
    output axi_req_t sram_req,
    input  axi_rsp_t sram_rsp,
    output axi_req_t uart_req,
    input  axi_rsp_t uart_rsp,
    output axi_req_t clint_req,
    input  axi_rsp_t clint_rsp
);

    localparam addr_t SRAM_SIZE = addr_t'(SRAM_WORDS * 4);

    slave_sel_e sel_q;
    slave_sel_e sel_d;
    logic       busy;
    logic       done;
    addr_t      dec_addr;
    axi_rsp_t   de_rsp;
    logic       de_rvalid;
    logic       de_bvalid;
    logic       de_idle;

    function automatic slave_sel_e decode(addr_t addr);
        slave_sel_e sel;
        sel = SEL_NONE;
        if (addr_t'(addr - SRAM_BASE) < SRAM_SIZE) begin
            sel = SEL_SRAM;
        end else if (addr_t'(addr - UART_BASE) < UART_SIZE) begin
            sel = SEL_UART;
        end else if (addr_t'(addr - CLINT_BASE) < CLINT_SIZE) begin
            sel = SEL_CLINT;
        end
        return sel;
    endfunction

    assign dec_addr = up_req.ar.arvalid ? up_req.ar.araddr : up_req.aw.awaddr;
    assign sel_d    = decode(dec_addr);
    assign done     = (up_rsp.r.rvalid && up_req.rready) ||
                      (up_rsp.b.bvalid && up_req.bready);

    // Selection held until the response handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            sel_q <= SEL_NONE;
        end else if (!busy) begin
            if (up_req.ar.arvalid || up_req.aw.awvalid) begin
                busy  <= 1'b1;
                sel_q <= sel_d;
            end
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // DECERR responder for unmapped addresses
    assign de_idle = busy && (sel_q == SEL_NONE) && !de_rvalid && !de_bvalid;

    always_comb begin
        de_rsp          = '0;
        de_rsp.arready  = de_idle;
        de_rsp.awready  = de_idle && up_req.aw.awvalid && up_req.w.wvalid;
        de_rsp.wready   = de_rsp.awready;
        de_rsp.r.rresp  = RESP_DECERR;
        de_rsp.r.rvalid = de_rvalid;
        de_rsp.b.bresp  = RESP_DECERR;
        de_rsp.b.bvalid = de_bvalid;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_rvalid <= 1'b0;
            de_bvalid <= 1'b0;
        end else begin
            if (up_req.ar.arvalid && de_rsp.arready) begin
                de_rvalid <= 1'b1;
            end else if (up_req.rready) begin
                de_rvalid <= 1'b0;
            end
            if (de_rsp.awready) begin
                de_bvalid <= 1'b1;
            end else if (up_req.bready) begin
                de_bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        sram_req  = '0;
        uart_req  = '0;
        clint_req = '0;
        up_rsp    = '0;
        if (busy) begin
            case (sel_q)
                SEL_SRAM: begin
                    sram_req = up_req;
                    up_rsp   = sram_rsp;
                end
                SEL_UART: begin
                    uart_req = up_req;
                    up_rsp   = uart_rsp;
                end
                SEL_CLINT: begin
                    clint_req = up_req;
                    up_rsp    = clint_rsp;
                end
                default: up_rsp = de_rsp;
            endcase
        end
    end

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sram_req.ar.arvalid || sram_req.aw.awvalid || sram_req.w.wvalid,
                  uart_req.ar.arvalid || uart_req.aw.awvalid || uart_req.w.wvalid,
                  clint_req.ar.arvalid || clint_req.aw.awvalid || clint_req.w.wvalid}));

endmodule

`default_nettype wire

//--- design/clint_slave.sv
`timescale 1ns/1ps
`default_nettype none

module clint_slave import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  axi_req_t req,
    output axi_rsp_t rsp,
    output logic     timer_irq
);

    data_t mtime;
    data_t mtimecmp;
    data_t rd_mux;
    data_t rdata_q;
    logic  rvalid_q;
    logic  bvalid_q;
    logic  idle;
    logic  ar_hs;
    logic  wr_hs;
    logic  cmp_wr;

    assign idle   = !rvalid_q && !bvalid_q;
    assign ar_hs  = req.ar.arvalid && idle;
    assign wr_hs  = req.aw.awvalid && req.w.wvalid && idle && !req.ar.arvalid;
    // mtime is read-only, only mtimecmp takes writes
    assign cmp_wr = wr_hs && (req.aw.awaddr[15:0] == CLINT_MTIMECMP_OFF[15:0]);

    always_comb begin
        case (req.ar.araddr[15:0])
            CLINT_MTIMECMP_OFF[15:0]: rd_mux = mtimecmp;
            CLINT_MTIME_OFF[15:0]:    rd_mux = mtime;
            default:                  rd_mux = '0;
        endcase
    end

    always_comb begin
        rsp          = '0;
        rsp.arready  = idle;
        rsp.awready  = wr_hs;
        rsp.wready   = wr_hs;
        rsp.r.rdata  = rdata_q;
        rsp.r.rresp  = RESP_OKAY;
        rsp.r.rvalid = rvalid_q;
        rsp.b.bresp  = RESP_OKAY;
        rsp.b.bvalid = bvalid_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            mtime     <= '0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            rvalid_q  <= ar_hs || (rvalid_q && !req.rready);
            bvalid_q  <= wr_hs || (bvalid_q && !req.bready);
            mtime     <= mtime + 32'd1;
            timer_irq <= (mtime >= mtimecmp);
            for (int i = 0; i < 4; i++) begin
                if (cmp_wr && req.w.wstrb[i]) begin
                    mtimecmp[8*i +: 8] <= req.w.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- design/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        SEL_SRAM  = 2'd0,
        SEL_UART  = 2'd1,
        SEL_CLINT = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_M0,
        ARB_M1
    } arb_state_e;

    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
    } axi_ar_t;

    typedef struct packed {
        data_t rdata;
        resp_e rresp;
        logic  rvalid;
    } axi_r_t;

    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
    } axi_aw_t;

    typedef struct packed {
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
    } axi_w_t;

    typedef struct packed {
        resp_e bresp;
        logic  bvalid;
    } axi_b_t;

    // Everything a master drives
    typedef struct packed {
        axi_ar_t ar;
        axi_aw_t aw;
        axi_w_t  w;
        logic    rready;
        logic    bready;
    } axi_req_t;

    // Everything a slave drives
    typedef struct packed {
        axi_r_t r;
        axi_b_t b;
        logic   arready;
        logic   awready;
        logic   wready;
    } axi_rsp_t;

    localparam addr_t SRAM_BASE  = 32'h8000_0000;

    // THR at offset 0, LSR sits in lane 1 of the word at base+4
    localparam addr_t UART_BASE    = 32'ha000_03f8;
    localparam addr_t UART_SIZE    = 32'h0000_0008;
    localparam data_t UART_LSR_VAL = 32'h0000_6000;

    localparam addr_t CLINT_BASE         = 32'h0200_0000;
    localparam addr_t CLINT_SIZE         = 32'h0001_0000;
    localparam addr_t CLINT_MTIMECMP_OFF = 32'h0000_4000;
    localparam addr_t CLINT_MTIME_OFF    = 32'h0000_bff8;

endpackage

`default_nettype wire

//--- design/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_bus_pkg::*; #(
    parameter int SRAM_WORDS = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    input  axi_req_t   m0_req,
    output axi_rsp_t   m0_rsp,
    input  axi_req_t   m1_req,
    output axi_rsp_t   m1_rsp,
    output logic [7:0] uart_tx_data,
    output logic       uart_tx_valid,
    output logic       timer_irq
);

    axi_req_t bus_req;
    axi_rsp_t bus_rsp;
    axi_req_t sram_req;
    axi_rsp_t sram_rsp;
    axi_req_t uart_req;
    axi_rsp_t uart_rsp;
    axi_req_t clint_req;
    axi_rsp_t clint_rsp;

    axi_lite_arbiter u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .m0_req  (m0_req),
        .m0_rsp  (m0_rsp),
        .m1_req  (m1_req),
        .m1_rsp  (m1_rsp),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    axi_xbar #(.SRAM_WORDS(SRAM_WORDS)) u_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .up_req    (bus_req),
        .up_rsp    (bus_rsp),
        .sram_req  (sram_req),
        .sram_rsp  (sram_rsp),
        .uart_req  (uart_req),
        .uart_rsp  (uart_rsp),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp)
    );

    sram_slave #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

    uart_slave u_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (uart_req),
        .rsp      (uart_rsp),
        .tx_data  (uart_tx_data),
        .tx_valid (uart_tx_valid)
    );

    clint_slave u_clint (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (clint_req),
        .rsp       (clint_rsp),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

//--- design/sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_slave import soc_bus_pkg::*; #(
    parameter int SRAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  axi_req_t req,
    output axi_rsp_t rsp
);

    localparam int IDX_W = $clog2(SRAM_WORDS);

    data_t            mem [SRAM_WORDS];
    data_t            rdata_q;
    logic             rvalid_q;
    logic             bvalid_q;
    logic             idle;
    logic             ar_hs;
    logic             wr_hs;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign idle   = !rvalid_q && !bvalid_q;
    assign ar_hs  = req.ar.arvalid && idle;
    // Write waits until address and data are both offered
    assign wr_hs  = req.aw.awvalid && req.w.wvalid && idle && !req.ar.arvalid;
    assign rd_idx = req.ar.araddr[IDX_W+1:2];
    assign wr_idx = req.aw.awaddr[IDX_W+1:2];

    always_comb begin
        rsp          = '0;
        rsp.arready  = idle;
        rsp.awready  = wr_hs;
        rsp.wready   = wr_hs;
        rsp.r.rdata  = rdata_q;
        rsp.r.rresp  = RESP_OKAY;
        rsp.r.rvalid = rvalid_q;
        rsp.b.bresp  = RESP_OKAY;
        rsp.b.bvalid = bvalid_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            rvalid_q <= ar_hs || (rvalid_q && !req.rready);
            bvalid_q <= wr_hs || (bvalid_q && !req.bready);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= mem[rd_idx];
        end
        if (wr_hs) begin
            for (int i = 0; i < 4; i++) begin
                if (req.w.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= req.w.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/uart_slave.sv
`timescale 1ns/1ps
`default_nettype none

module uart_slave import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  axi_req_t   req,
    output axi_rsp_t   rsp,
    output logic [7:0] tx_data,
    output logic       tx_valid
);

    data_t rdata_q;
    logic  rvalid_q;
    logic  bvalid_q;
    logic  idle;
    logic  ar_hs;
    logic  wr_hs;
    logic  thr_wr;

    assign idle   = !rvalid_q && !bvalid_q;
    assign ar_hs  = req.ar.arvalid && idle;
    assign wr_hs  = req.aw.awvalid && req.w.wvalid && idle && !req.ar.arvalid;
    // THR is the word at offset 0, lane 0
    assign thr_wr = wr_hs && !req.aw.awaddr[2] && req.w.wstrb[0];

    always_comb begin
        rsp          = '0;
        rsp.arready  = idle;
        rsp.awready  = wr_hs;
        rsp.wready   = wr_hs;
        rsp.r.rdata  = rdata_q;
        rsp.r.rresp  = RESP_OKAY;
        rsp.r.rvalid = rvalid_q;
        rsp.b.bresp  = RESP_OKAY;
        rsp.b.bvalid = bvalid_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            rvalid_q <= ar_hs || (rvalid_q && !req.rready);
            bvalid_q <= wr_hs || (bvalid_q && !req.bready);
            tx_valid <= thr_wr;
        end
    end

    // Transmitter always reported empty
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= req.ar.araddr[2] ? UART_LSR_VAL : '0;
        end
        if (thr_wr) begin
            tx_data <= req.w.wdata[7:0];
        end
    end

endmodule

`default_nettype wire

//--- project.f
design/soc_bus_pkg.sv
design/axi_lite_arbiter.sv
design/axi_xbar.sv
design/sram_slave.sv
design/uart_slave.sv
design/clint_slave.sv
design/soc_top.sv
tests/tb_soc_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f project.f \
    --top-module tb_soc_top -o sim_soc \
    && ./obj_dir/sim_soc > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- tests/tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top
    import soc_bus_pkg::*;
();

    localparam int SRAM_WORDS = 256;
    // Roughly 250 transactions of at most 16 cycles each
    localparam int TIMEOUT_CYCLES = 250 * 16;

    logic       clk;
    logic       rst_n;
    axi_req_t   m_req [2];
    axi_rsp_t   m_rsp [2];
    logic [7:0] uart_tx_data;
    logic       uart_tx_valid;
    logic       timer_irq;

    data_t      shadow [SRAM_WORDS];
    logic [7:0] tx_seen_q [$];
    string      dname_q [$];
    data_t      dexp_q [$];
    data_t      dact_q [$];
    string      rname_q [$];
    resp_e      rexp_q [$];
    resp_e      ract_q [$];
    string      cur_test;
    int         cycles;
    int         err_count;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         done_cnt [2];

    soc_top #(.SRAM_WORDS(SRAM_WORDS)) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .m0_req        (m_req[0]),
        .m0_rsp        (m_rsp[0]),
        .m1_req        (m_req[1]),
        .m1_rsp        (m_rsp[1]),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid),
        .timer_irq     (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // Expected memory map contents
    function automatic data_t ref_read(input addr_t addr, output resp_e resp);
        data_t data;
        resp = RESP_OKAY;
        data = '0;
        if ((addr - SRAM_BASE) < SRAM_WORDS * 4) begin
            data = shadow[(addr - SRAM_BASE) >> 2];
        end else if ((addr - UART_BASE) < 8) begin
            data = (addr == UART_BASE + 4) ? 32'h0000_6000 : 32'h0;
        end else if ((addr - CLINT_BASE) >= 32'h0001_0000) begin
            resp = RESP_DECERR;
        end
        return data;
    endfunction

    function automatic void ref_write(input addr_t addr, input data_t data, input strb_t strb);
        if ((addr - SRAM_BASE) < SRAM_WORDS * 4) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    shadow[(addr - SRAM_BASE) >> 2][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, name, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_resp(input string name, input resp_e exp, input resp_e act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %s, actual %s (%b)",
                     cur_test, name, exp.name(), act.name(), act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        if (cond !== 1'b1) begin
            $display("[%s] %s", cur_test, what);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic expect_data(input string name, input data_t exp, input data_t act);
        dname_q.push_back(name);
        dexp_q.push_back(exp);
        dact_q.push_back(act);
    endtask

    task automatic expect_resp(input string name, input resp_e exp, input resp_e act);
        rname_q.push_back(name);
        rexp_q.push_back(exp);
        ract_q.push_back(act);
    endtask

    // Compare process draining the pending results
    always @(negedge clk) begin
        while (dname_q.size() > 0) begin
            check_data(dname_q.pop_front(), dexp_q.pop_front(), dact_q.pop_front());
        end
        while (rname_q.size() > 0) begin
            check_resp(rname_q.pop_front(), rexp_q.pop_front(), ract_q.pop_front());
        end
    end

    always @(negedge clk) begin
        if (rst_n && uart_tx_valid) begin
            tx_seen_q.push_back(uart_tx_data);
        end
    end

    task automatic axi_read(input int m, input addr_t addr, output data_t data,
                            output resp_e resp);
        int delay;
        int other_seen;
        delay = $urandom_range(3, 0);
        other_seen = done_cnt[1 - m];
        @(posedge clk);
        m_req[m].ar.araddr <= addr;
        m_req[m].ar.arvalid <= 1'b1;
        do @(negedge clk); while (!m_rsp[m].arready);
        @(posedge clk);
        m_req[m].ar.arvalid <= 1'b0;
        do @(negedge clk); while (!m_rsp[m].r.rvalid);
        repeat (delay + 1) @(posedge clk);
        m_req[m].rready <= 1'b1;
        @(negedge clk);
        data = m_rsp[m].r.rdata;
        resp = m_rsp[m].r.rresp;
        @(posedge clk);
        m_req[m].rready <= 1'b0;
        done_cnt[m]++;
        expect_true(done_cnt[1 - m] - other_seen <= 1,
                    $sformatf("m%0d read waited through more than one other transaction", m));
    endtask

    task automatic axi_write(input int m, input addr_t addr, input data_t data,
                             input strb_t strb, output resp_e resp);
        int   delay;
        int   other_seen;
        logic aw_done;
        logic w_done;
        delay = $urandom_range(3, 0);
        other_seen = done_cnt[1 - m];
        aw_done = 1'b0;
        w_done = 1'b0;
        @(posedge clk);
        m_req[m].aw.awaddr <= addr;
        m_req[m].aw.awvalid <= 1'b1;
        m_req[m].w.wdata <= data;
        m_req[m].w.wstrb <= strb;
        m_req[m].w.wvalid <= 1'b1;
        // AW and W may complete on different cycles
        while (!aw_done || !w_done) begin
            @(negedge clk);
            aw_done = aw_done || m_rsp[m].awready;
            w_done = w_done || m_rsp[m].wready;
            @(posedge clk);
            m_req[m].aw.awvalid <= !aw_done;
            m_req[m].w.wvalid <= !w_done;
        end
        do @(negedge clk); while (!m_rsp[m].b.bvalid);
        repeat (delay + 1) @(posedge clk);
        m_req[m].bready <= 1'b1;
        @(negedge clk);
        resp = m_rsp[m].b.bresp;
        @(posedge clk);
        m_req[m].bready <= 1'b0;
        done_cnt[m]++;
        expect_true(done_cnt[1 - m] - other_seen <= 1,
                    $sformatf("m%0d write waited through more than one other transaction", m));
    endtask

    task automatic read_check(input int m, input addr_t addr);
        data_t act;
        data_t exp;
        resp_e act_resp;
        resp_e exp_resp;
        axi_read(m, addr, act, act_resp);
        exp = ref_read(addr, exp_resp);
        expect_data($sformatf("m%0d read %h", m, addr), exp, act);
        expect_resp($sformatf("m%0d read %h", m, addr), exp_resp, act_resp);
    endtask

    task automatic write_model(input int m, input addr_t addr, input data_t data,
                               input strb_t strb);
        resp_e act_resp;
        resp_e exp_resp;
        axi_write(m, addr, data, strb, act_resp);
        ref_write(addr, data, strb);
        void'(ref_read(addr, exp_resp));
        expect_resp($sformatf("m%0d write %h", m, addr), exp_resp, act_resp);
    endtask

    // Each master stays in its own half of the SRAM
    task automatic arb_stream(input int m);
        addr_t a;
        for (int i = 0; i < 30; i++) begin
            a = SRAM_BASE + ((m * SRAM_WORDS / 2 + $urandom_range(SRAM_WORDS / 2 - 1, 0)) << 2);
            write_model(m, a, $urandom, 4'hf);
            read_check(m, a);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        repeat (2) @(negedge clk);
        tests_run++;
        if (test_errs == 0) begin
            $display("[PASS] %s", cur_test);
        end else begin
            tests_failed++;
            $display("[FAIL] %s with %0d errors", cur_test, test_errs);
        end
    endtask

    initial begin
        addr_t      addrs [40];
        logic [7:0] tx_exp [8];
        data_t      d;
        data_t      t1;
        data_t      t2;
        resp_e      r;
        int         n;
        rst_n = 1'b0;
        m_req[0] = '0;
        m_req[1] = '0;
        void'($urandom(59));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset_state");
        @(negedge clk);
        expect_true({m_rsp[0].r.rvalid, m_rsp[0].b.bvalid, m_rsp[0].arready, m_rsp[0].awready,
                     m_rsp[0].wready, m_rsp[1].r.rvalid, m_rsp[1].b.bvalid, m_rsp[1].arready,
                     m_rsp[1].awready, m_rsp[1].wready, uart_tx_valid, timer_irq} == '0,
                    "a valid, ready, tx_valid or timer_irq output is high after reset");
        end_test();

        begin_test("sram_rw");
        for (int i = 0; i < 40; i++) begin
            addrs[i] = SRAM_BASE + ($urandom_range(SRAM_WORDS - 1, 0) << 2);
            write_model(0, addrs[i], $urandom, 4'hf);
        end
        // Partial overwrites of words that already hold known data
        for (int i = 0; i < 40; i += 4) begin
            write_model(1, addrs[i], $urandom, strb_t'($urandom_range(14, 1)));
        end
        for (int i = 0; i < 40; i++) begin
            read_check(i % 2, addrs[i]);
        end
        end_test();

        begin_test("unmapped");
        for (int i = 0; i < 10; i++) begin
            d = 32'h4000_0000 | ($urandom & 32'h0fff_fffc);
            write_model(i % 2, d, $urandom, 4'hf);
            read_check(1 - i % 2, d);
        end
        read_check(0, SRAM_BASE + SRAM_WORDS * 4);
        end_test();

        begin_test("uart");
        tx_seen_q.delete();
        for (int i = 0; i < 8; i++) begin
            d = $urandom;
            tx_exp[i] = d[7:0];
            write_model(i % 2, UART_BASE, d, 4'h1);
        end
        repeat (2) @(negedge clk);
        expect_true(tx_seen_q.size() == 8,
                    $sformatf("saw %0d tx_valid pulses for 8 writes", tx_seen_q.size()));
        for (int i = 0; i < 8 && i < tx_seen_q.size(); i++) begin
            expect_data($sformatf("tx byte %0d", i), data_t'(tx_exp[i]), data_t'(tx_seen_q[i]));
        end
        read_check(1, UART_BASE + 4);
        end_test();

        begin_test("clint");
        axi_read(0, CLINT_BASE + CLINT_MTIME_OFF, t1, r);
        expect_resp("mtime read 1", RESP_OKAY, r);
        axi_read(1, CLINT_BASE + CLINT_MTIME_OFF, t2, r);
        expect_resp("mtime read 2", RESP_OKAY, r);
        expect_true(t2 > t1, $sformatf("mtime did not increase: %h then %h", t1, t2));
        axi_write(0, CLINT_BASE + CLINT_MTIMECMP_OFF, t2 + 50, 4'hf, r);
        expect_resp("mtimecmp write", RESP_OKAY, r);
        @(negedge clk);
        expect_true(!timer_irq, "timer_irq rose as soon as mtimecmp was set ahead");
        n = 0;
        while (!timer_irq && n < 100) begin
            @(negedge clk);
            n++;
        end
        expect_true(timer_irq, "timer_irq did not rise within 100 cycles");
        axi_write(1, CLINT_BASE + CLINT_MTIMECMP_OFF, '1, 4'hf, r);
        expect_resp("mtimecmp clear", RESP_OKAY, r);
        n = 0;
        while (timer_irq && n < 3) begin
            @(negedge clk);
            n++;
        end
        expect_true(!timer_irq, "timer_irq stayed high after mtimecmp was set to all ones");
        end_test();

        begin_test("arbitration");
        fork
            arb_stream(0);
            arb_stream(1);
        join
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
